// ==== filelist.f ====
+incdir+source
source/axi_bridge_pkg.sv
source/axi_chan_slice.sv
source/axi_lite_to_axi.sv
source/axi_lite_bridge_top.sv
dv/tb_bridge_checker.sv
dv/tb_axi_lite_to_axi.sv

// ==== Makefile ====
# Verilator build and run for the AXI4-Lite to AXI4 bridge

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= tb_axi_lite_to_axi
LINT_TOP  ?= axi_lite_bridge_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/tb_axi_lite_to_axi.sv ====
// Testbench for the AXI4-Lite to AXI4 bridge with lite master stimulus and an AXI4 slave memory
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_macros.svh"

module tb_axi_lite_to_axi
  import axi_bridge_pkg::*;
;

  localparam addr_t base_addr = 32'h4000_0000;
  // 8+8 plain, 20+20 under back-pressure, 6+6 with held responses
  localparam int n_trans = 68;
  localparam int timeout_ns = (n_trans * 40 + 200) * 10;

  logic clk;
  logic rst_n;
  lite_aw_t lite_aw;
  logic     lite_aw_valid;
  logic     lite_aw_ready;
  lite_w_t  lite_w;
  logic     lite_w_valid;
  logic     lite_w_ready;
  lite_b_t  lite_b;
  logic     lite_b_valid;
  logic     lite_b_ready;
  lite_ar_t lite_ar;
  logic     lite_ar_valid;
  logic     lite_ar_ready;
  lite_r_t  lite_r;
  logic     lite_r_valid;
  logic     lite_r_ready;
  axi_aw_t  axi_aw;
  logic     axi_aw_valid;
  logic     axi_aw_ready;
  axi_w_t   axi_w;
  logic     axi_w_valid;
  logic     axi_w_ready;
  axi_b_t   axi_b;
  logic     axi_b_valid;
  logic     axi_b_ready;
  axi_ar_t  axi_ar;
  logic     axi_ar_valid;
  logic     axi_ar_ready;
  axi_r_t   axi_r;
  logic     axi_r_valid;
  logic     axi_r_ready;

  logic [15:0] lfsr;
  logic        bp_en;
  logic        hold_b;
  logic        hold_r;
  logic        wr_busy;
  logic        rd_busy;
  int          b_seen;
  int          rd_seen;
  int          tb_errs;
  data_t       mem[16];
  data_t       exp_mem[16];
  data_t       exp_rd_q[$];
  axi_aw_t     slv_aw_q[$];
  axi_w_t      slv_w_q[$];
  axi_ar_t     slv_ar_q[$];
  axi_b_t      slv_b_q[$];

  axi_lite_bridge_top dut (.*);
  tb_bridge_checker u_chk (.*);

  always #5 clk = ~clk;

  // Fibonacci LFSR with taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step for every bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Initial memory content depends on every address bit
  function automatic data_t fill_word(input addr_t a);
    return a ^ 32'h5A5A_C3C3 ^ {a[15:0], a[31:16]};
  endfunction

  // Ready patterns on the slave request side and the master response side
  always @(posedge clk) begin
    #1;
    axi_aw_ready = bp_en ? 1'(rand_bits(1)) : 1'b1;
    axi_w_ready  = bp_en ? 1'(rand_bits(1)) : 1'b1;
    axi_ar_ready = bp_en ? 1'(rand_bits(1)) : 1'b1;
    lite_b_ready = bp_en ? 1'(rand_bits(1)) : 1'b1;
    lite_r_ready = bp_en ? 1'(rand_bits(1)) : 1'b1;
  end

  // AXI4 slave memory model, one response per request and in order
  always @(posedge clk) begin
    axi_aw_t a;
    axi_w_t  w;
    axi_ar_t r;
    logic    b_done;
    logic    r_done;
    if (axi_aw_valid && axi_aw_ready) slv_aw_q.push_back(axi_aw);
    if (axi_w_valid && axi_w_ready) slv_w_q.push_back(axi_w);
    if (axi_ar_valid && axi_ar_ready) slv_ar_q.push_back(axi_ar);
    b_done = axi_b_valid && axi_b_ready;
    r_done = axi_r_valid && axi_r_ready;
    while (slv_aw_q.size() > 0 && slv_w_q.size() > 0) begin
      a = slv_aw_q.pop_front();
      w = slv_w_q.pop_front();
      for (int i = 0; i < 4; i++) begin
        if (w.strb[i]) mem[a.addr[5:2]][8*i +: 8] = w.data[8*i +: 8];
      end
      slv_b_q.push_back('{id: a.id, resp: resp_t'(rand_bits(2)), user: '0});
    end
    #1;
    if (b_done) axi_b_valid = 1'b0;
    if (r_done) axi_r_valid = 1'b0;
    // Held responses only delay raising valid, a raised valid stays up
    if (!axi_b_valid && !hold_b && slv_b_q.size() > 0) begin
      axi_b = slv_b_q.pop_front();
      axi_b_valid = 1'b1;
    end
    if (!axi_r_valid && !hold_r && slv_ar_q.size() > 0) begin
      r = slv_ar_q.pop_front();
      axi_r = '{id: r.id, data: mem[r.addr[5:2]], resp: resp_t'(rand_bits(2)),
                last: 1'b1, user: '0};
      axi_r_valid = 1'b1;
    end
  end

  // Lite side response bookkeeping and read-back comparison
  always @(posedge clk) begin
    data_t exp;
    if (rst_n && lite_b_valid && lite_b_ready) b_seen++;
    if (rst_n && lite_r_valid && lite_r_ready) begin
      rd_seen++;
      if (exp_rd_q.size() == 0) begin
        $display("Lite R beat arrived with no read outstanding at %0t", $time);
        tb_errs++;
      end else begin
        exp = exp_rd_q.pop_front();
        if (lite_r.data !== exp) begin
          $display("** Error %0t: read-back data %h, expected %h", $time, lite_r.data, exp);
          tb_errs++;
        end
      end
    end
  end

  // All send tasks start 1 ns after an edge and return at the same phase
  task automatic send_aw(input addr_t a, input prot_t p);
    lite_aw = '{addr: a, prot: p};
    lite_aw_valid = 1'b1;
    do @(posedge clk); while (!lite_aw_ready);
    #1 lite_aw_valid = 1'b0;
  endtask

  task automatic send_w(input lite_w_t w);
    lite_w = w;
    lite_w_valid = 1'b1;
    do @(posedge clk); while (!lite_w_ready);
    #1 lite_w_valid = 1'b0;
  endtask

  task automatic send_ar(input addr_t a, input prot_t p);
    lite_ar = '{addr: a, prot: p};
    lite_ar_valid = 1'b1;
    do @(posedge clk); while (!lite_ar_ready);
    #1 lite_ar_valid = 1'b0;
  endtask

  // Issue n writes with AW and W streams independent, then wait for all B
  task automatic do_writes(input int n);
    addr_t   addrs[$];
    lite_w_t words[$];
    logic [3:0] idx;
    lite_w_t w;
    int      target;
    target = b_seen + n;
    for (int k = 0; k < n; k++) begin
      idx = 4'(rand_bits(4));
      w.data = rand_bits(32);
      w.strb = strb_t'(rand_bits(4));
      for (int i = 0; i < 4; i++) begin
        if (w.strb[i]) exp_mem[idx][8*i +: 8] = w.data[8*i +: 8];
      end
      addrs.push_back(base_addr + 32'(idx) * 4);
      words.push_back(w);
    end
    fork
      foreach (addrs[i]) send_aw(addrs[i], prot_t'(rand_bits(3)));
      foreach (words[i]) send_w(words[i]);
    join
    while (b_seen < target) @(posedge clk);
    #1;
  endtask

  task automatic do_reads(input int n);
    logic [3:0] idx;
    int target;
    target = rd_seen + n;
    for (int k = 0; k < n; k++) begin
      idx = 4'(rand_bits(4));
      exp_rd_q.push_back(exp_mem[idx]);
      send_ar(base_addr + 32'(idx) * 4, prot_t'(rand_bits(3)));
    end
    while (rd_seen < target) @(posedge clk);
    #1;
  endtask

  // Watchdog sized from the transaction count
  initial begin
    #(timeout_ns);
    $display("Timeout: the run did not finish within %0d ns", timeout_ns);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    int start;
    int total;
    clk = 1'b0;
    rst_n = 1'b0;
    lfsr = 16'd73;
    bp_en = 1'b0;
    hold_b = 1'b0;
    hold_r = 1'b0;
    wr_busy = 1'b0;
    rd_busy = 1'b0;
    b_seen = 0;
    rd_seen = 0;
    tb_errs = 0;
    lite_aw = '0;
    lite_aw_valid = 1'b0;
    lite_w = '0;
    lite_w_valid = 1'b0;
    lite_b_ready = 1'b1;
    lite_ar = '0;
    lite_ar_valid = 1'b0;
    lite_r_ready = 1'b1;
    axi_aw_ready = 1'b1;
    axi_w_ready = 1'b1;
    axi_b = '0;
    axi_b_valid = 1'b0;
    axi_ar_ready = 1'b1;
    axi_r = '0;
    axi_r_valid = 1'b0;
    for (int i = 0; i < 16; i++) begin
      mem[i] = fill_word(base_addr + 32'(i) * 4);
      exp_mem[i] = mem[i];
    end
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (2) @(posedge clk);
    #1;

    // Plain translation with every ready high
    do_writes(8);
    do_reads(8);

    // Random back-pressure on both sides
    bp_en = 1'b1;
    do_writes(20);
    do_reads(20);
    bp_en = 1'b0;
    repeat (4) @(posedge clk);
    #1;

    // Writes with B withheld must stop at the outstanding limit
    hold_b = 1'b1;
    wr_busy = 1'b1;
    start = u_chk.axi_aw_cnt;
    fork
      begin
        do_writes(6);
        wr_busy = 1'b0;
      end
    join_none
    repeat (60) @(posedge clk);
    #1;
    if (u_chk.axi_aw_cnt - start != `AXI_BRIDGE_MAX_OUT) begin
      $display("Write limit not met, %0d AW beats passed while B was held",
               u_chk.axi_aw_cnt - start);
      tb_errs++;
    end
    hold_b = 1'b0;
    while (wr_busy) @(posedge clk);
    #1;

    // Same for reads with R withheld
    hold_r = 1'b1;
    rd_busy = 1'b1;
    start = u_chk.axi_ar_cnt;
    fork
      begin
        do_reads(6);
        rd_busy = 1'b0;
      end
    join_none
    repeat (60) @(posedge clk);
    #1;
    if (u_chk.axi_ar_cnt - start != `AXI_BRIDGE_MAX_OUT) begin
      $display("Read limit not met, %0d AR beats passed while R was held",
               u_chk.axi_ar_cnt - start);
      tb_errs++;
    end
    hold_r = 1'b0;
    while (rd_busy) @(posedge clk);
    repeat (5) @(posedge clk);
    #1;

    total = u_chk.value_errs + u_chk.order_errs + u_chk.leftover() + tb_errs;
    $display("Errors: value %0d, order %0d, unmatched %0d, testbench %0d",
             u_chk.value_errs, u_chk.order_errs, u_chk.leftover(), tb_errs);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/tb_bridge_checker.sv ====
// Bridge checker that predicts every AXI4 request and lite response from the lite and slave beats
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_macros.svh"

module tb_bridge_checker
  import axi_bridge_pkg::*;
(
  input wire logic     clk,
  input wire logic     rst_n,
  input wire lite_aw_t lite_aw,
  input wire logic     lite_aw_valid,
  input wire logic     lite_aw_ready,
  input wire lite_w_t  lite_w,
  input wire logic     lite_w_valid,
  input wire logic     lite_w_ready,
  input wire lite_b_t  lite_b,
  input wire logic     lite_b_valid,
  input wire logic     lite_b_ready,
  input wire lite_ar_t lite_ar,
  input wire logic     lite_ar_valid,
  input wire logic     lite_ar_ready,
  input wire lite_r_t  lite_r,
  input wire logic     lite_r_valid,
  input wire logic     lite_r_ready,
  input wire axi_aw_t  axi_aw,
  input wire logic     axi_aw_valid,
  input wire logic     axi_aw_ready,
  input wire axi_w_t   axi_w,
  input wire logic     axi_w_valid,
  input wire logic     axi_w_ready,
  input wire axi_b_t   axi_b,
  input wire logic     axi_b_valid,
  input wire logic     axi_b_ready,
  input wire axi_ar_t  axi_ar,
  input wire logic     axi_ar_valid,
  input wire logic     axi_ar_ready,
  input wire axi_r_t   axi_r,
  input wire logic     axi_r_valid,
  input wire logic     axi_r_ready
);

  lite_aw_t aw_q[$];
  lite_w_t  w_q[$];
  lite_ar_t ar_q[$];
  axi_b_t   b_q[$];
  axi_r_t   r_q[$];
  int value_errs = 0;
  int order_errs = 0;
  int axi_aw_cnt = 0;
  int axi_ar_cnt = 0;
  int lite_b_cnt = 0;
  int lite_r_cnt = 0;
  logic rst_q = 1'b0;

  // Single-beat INCR request of one full 4-byte word with fixed ID
  function automatic axi_aw_t expect_addr(input lite_aw_t l);
    axi_aw_t a;
    a = '0;
    a.id    = `AXI_BRIDGE_ID;
    a.addr  = l.addr;
    a.size  = 3'd2;
    a.burst = 2'b01;
    a.prot  = l.prot;
    return a;
  endfunction

  function automatic axi_w_t expect_w(input lite_w_t l);
    return '{data: l.data, strb: l.strb, last: 1'b1, user: '0};
  endfunction

  function automatic resp_t expect_resp(input resp_t r);
    case (r)
      resp_exokay: return resp_okay;
      default:     return r;
    endcase
  endfunction

  function automatic int leftover();
    return aw_q.size() + w_q.size() + ar_q.size() + b_q.size() + r_q.size();
  endfunction

  always @(posedge clk) begin
    lite_aw_t la;
    lite_w_t  lw;
    axi_b_t   eb;
    axi_r_t   er;
    rst_q <= rst_n;
    // Valid outputs stay low in reset and on the first edge after it
    if ((!rst_n || !rst_q) &&
        (lite_b_valid || lite_r_valid || axi_aw_valid || axi_w_valid || axi_ar_valid)) begin
      $display("** Error %0t: a DUT valid output is high around reset", $time);
      value_errs++;
    end
    if (rst_n) begin
      if (lite_aw_valid && lite_aw_ready) aw_q.push_back(lite_aw);
      if (lite_w_valid && lite_w_ready) w_q.push_back(lite_w);
      if (lite_ar_valid && lite_ar_ready) ar_q.push_back(lite_ar);
      if (axi_b_valid && axi_b_ready) b_q.push_back(axi_b);
      if (axi_r_valid && axi_r_ready) r_q.push_back(axi_r);
      if (axi_aw_valid && axi_aw_ready) begin
        axi_aw_cnt++;
        if (aw_q.size() == 0) begin
          $display("AXI4 AW beat at %0t had no lite AW request before it", $time);
          order_errs++;
        end else begin
          la = aw_q.pop_front();
          if (axi_aw !== expect_addr(la)) begin
            $display("** Error %0t: AW %h, expected %h", $time, axi_aw, expect_addr(la));
            value_errs++;
          end
        end
      end
      if (axi_w_valid && axi_w_ready) begin
        if (w_q.size() == 0) begin
          $display("AXI4 W beat at %0t had no lite W beat before it", $time);
          order_errs++;
        end else begin
          lw = w_q.pop_front();
          if (axi_w !== expect_w(lw)) begin
            $display("** Error %0t: W %h, expected %h", $time, axi_w, expect_w(lw));
            value_errs++;
          end
        end
      end
      if (axi_ar_valid && axi_ar_ready) begin
        axi_ar_cnt++;
        if (ar_q.size() == 0) begin
          $display("AXI4 AR beat at %0t had no lite AR request before it", $time);
          order_errs++;
        end else begin
          la = ar_q.pop_front();
          if (axi_ar !== expect_addr(la)) begin
            $display("** Error %0t: AR %h, expected %h", $time, axi_ar, expect_addr(la));
            value_errs++;
          end
        end
      end
      if (lite_b_valid && lite_b_ready) begin
        lite_b_cnt++;
        if (b_q.size() == 0) begin
          $display("Lite B beat at %0t had no AXI4 B response behind it", $time);
          order_errs++;
        end else begin
          eb = b_q.pop_front();
          if (lite_b.resp !== expect_resp(eb.resp)) begin
            $display("** Error %0t: lite B resp %0d, expected %0d", $time, lite_b.resp,
                     expect_resp(eb.resp));
            value_errs++;
          end
        end
      end
      if (lite_r_valid && lite_r_ready) begin
        lite_r_cnt++;
        if (r_q.size() == 0) begin
          $display("Lite R beat at %0t had no AXI4 R response behind it", $time);
          order_errs++;
        end else begin
          er = r_q.pop_front();
          if (lite_r.data !== er.data || lite_r.resp !== expect_resp(er.resp)) begin
            $display("** Error %0t: lite R %h/%0d, expected %h/%0d", $time, lite_r.data,
                     lite_r.resp, er.data, expect_resp(er.resp));
            value_errs++;
          end
        end
      end
      // Counts are updated above, so this covers the beats of this edge
      if (axi_aw_cnt - lite_b_cnt > `AXI_BRIDGE_MAX_OUT ||
          axi_ar_cnt - lite_r_cnt > `AXI_BRIDGE_MAX_OUT) begin
        $display("** Error %0t: outstanding limit exceeded, wr %0d rd %0d", $time,
                 axi_aw_cnt - lite_b_cnt, axi_ar_cnt - lite_r_cnt);
        value_errs++;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/axi_lite_bridge_top.sv ====
// AXI4-Lite to AXI4 bridge top level, the converter with a register slice on every AXI4 channel
`timescale 1ns/1ps
`default_nettype none

module axi_lite_bridge_top
  import axi_bridge_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst_n,

  // AXI4-Lite slave port
  input  wire lite_aw_t lite_aw,
  input  wire logic     lite_aw_valid,
  output logic          lite_aw_ready,
  input  wire lite_w_t  lite_w,
  input  wire logic     lite_w_valid,
  output logic          lite_w_ready,
  output lite_b_t       lite_b,
  output logic          lite_b_valid,
  input  wire logic     lite_b_ready,
  input  wire lite_ar_t lite_ar,
  input  wire logic     lite_ar_valid,
  output logic          lite_ar_ready,
  output lite_r_t       lite_r,
  output logic          lite_r_valid,
  input  wire logic     lite_r_ready,

  // AXI4 master port, every channel registered
  output axi_aw_t       axi_aw,
  output logic          axi_aw_valid,
  input  wire logic     axi_aw_ready,
  output axi_w_t        axi_w,
  output logic          axi_w_valid,
  input  wire logic     axi_w_ready,
  input  wire axi_b_t   axi_b,
  input  wire logic     axi_b_valid,
  output logic          axi_b_ready,
  output axi_ar_t       axi_ar,
  output logic          axi_ar_valid,
  input  wire logic     axi_ar_ready,
  input  wire axi_r_t   axi_r,
  input  wire logic     axi_r_valid,
  output logic          axi_r_ready
);

  // Converter side of each slice
  axi_aw_t conv_aw;
  logic    conv_aw_valid;
  logic    conv_aw_ready;
  axi_w_t  conv_w;
  logic    conv_w_valid;
  logic    conv_w_ready;
  axi_b_t  conv_b;
  logic    conv_b_valid;
  logic    conv_b_ready;
  axi_ar_t conv_ar;
  logic    conv_ar_valid;
  logic    conv_ar_ready;
  axi_r_t  conv_r;
  logic    conv_r_valid;
  logic    conv_r_ready;

  axi_lite_to_axi u_conv (
    .clk           (clk),
    .rst_n         (rst_n),
    .lite_aw       (lite_aw),
    .lite_aw_valid (lite_aw_valid),
    .lite_aw_ready (lite_aw_ready),
    .lite_w        (lite_w),
    .lite_w_valid  (lite_w_valid),
    .lite_w_ready  (lite_w_ready),
    .lite_b        (lite_b),
    .lite_b_valid  (lite_b_valid),
    .lite_b_ready  (lite_b_ready),
    .lite_ar       (lite_ar),
    .lite_ar_valid (lite_ar_valid),
    .lite_ar_ready (lite_ar_ready),
    .lite_r        (lite_r),
    .lite_r_valid  (lite_r_valid),
    .lite_r_ready  (lite_r_ready),
    .axi_aw        (conv_aw),
    .axi_aw_valid  (conv_aw_valid),
    .axi_aw_ready  (conv_aw_ready),
    .axi_w         (conv_w),
    .axi_w_valid   (conv_w_valid),
    .axi_w_ready   (conv_w_ready),
    .axi_b         (conv_b),
    .axi_b_valid   (conv_b_valid),
    .axi_b_ready   (conv_b_ready),
    .axi_ar        (conv_ar),
    .axi_ar_valid  (conv_ar_valid),
    .axi_ar_ready  (conv_ar_ready),
    .axi_r         (conv_r),
    .axi_r_valid   (conv_r_valid),
    .axi_r_ready   (conv_r_ready)
  );

  // Request slices run from the converter out to the slave
  axi_chan_slice #(.WIDTH($bits(axi_aw_t))) u_aw_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (conv_aw),
    .in_valid  (conv_aw_valid),
    .in_ready  (conv_aw_ready),
    .out_data  (axi_aw),
    .out_valid (axi_aw_valid),
    .out_ready (axi_aw_ready)
  );

  axi_chan_slice #(.WIDTH($bits(axi_w_t))) u_w_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (conv_w),
    .in_valid  (conv_w_valid),
    .in_ready  (conv_w_ready),
    .out_data  (axi_w),
    .out_valid (axi_w_valid),
    .out_ready (axi_w_ready)
  );

  axi_chan_slice #(.WIDTH($bits(axi_ar_t))) u_ar_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (conv_ar),
    .in_valid  (conv_ar_valid),
    .in_ready  (conv_ar_ready),
    .out_data  (axi_ar),
    .out_valid (axi_ar_valid),
    .out_ready (axi_ar_ready)
  );

  // Response slices run from the slave back into the converter
  axi_chan_slice #(.WIDTH($bits(axi_b_t))) u_b_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (axi_b),
    .in_valid  (axi_b_valid),
    .in_ready  (axi_b_ready),
    .out_data  (conv_b),
    .out_valid (conv_b_valid),
    .out_ready (conv_b_ready)
  );

  axi_chan_slice #(.WIDTH($bits(axi_r_t))) u_r_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (axi_r),
    .in_valid  (axi_r_valid),
    .in_ready  (axi_r_ready),
    .out_data  (conv_r),
    .out_valid (conv_r_valid),
    .out_ready (conv_r_ready)
  );

endmodule

`default_nettype wire

// ==== source/axi_lite_to_axi.sv ====
// AXI4-Lite to AXI4 protocol converter with field completion, response mapping and outstanding limits
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_macros.svh"

module axi_lite_to_axi
  import axi_bridge_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst_n,

  // AXI4-Lite slave port
  input  wire lite_aw_t lite_aw,
  input  wire logic     lite_aw_valid,
  output logic          lite_aw_ready,
  input  wire lite_w_t  lite_w,
  input  wire logic     lite_w_valid,
  output logic          lite_w_ready,
  output lite_b_t       lite_b,
  output logic          lite_b_valid,
  input  wire logic     lite_b_ready,
  input  wire lite_ar_t lite_ar,
  input  wire logic     lite_ar_valid,
  output logic          lite_ar_ready,
  output lite_r_t       lite_r,
  output logic          lite_r_valid,
  input  wire logic     lite_r_ready,

  // AXI4 master port
  output axi_aw_t       axi_aw,
  output logic          axi_aw_valid,
  input  wire logic     axi_aw_ready,
  output axi_w_t        axi_w,
  output logic          axi_w_valid,
  input  wire logic     axi_w_ready,
  input  wire axi_b_t   axi_b,
  input  wire logic     axi_b_valid,
  output logic          axi_b_ready,
  output axi_ar_t       axi_ar,
  output logic          axi_ar_valid,
  input  wire logic     axi_ar_ready,
  input  wire axi_r_t   axi_r,
  input  wire logic     axi_r_valid,
  output logic          axi_r_ready
);

  // Counter must reach the limit itself, hence one extra code point
  localparam int cnt_w = $clog2(`AXI_BRIDGE_MAX_OUT + 1);
  localparam logic [cnt_w-1:0] max_out = cnt_w'(`AXI_BRIDGE_MAX_OUT);

  // Every beat is one full data word
  localparam size_t  full_size  = size_t'($clog2(`AXI_BRIDGE_DATA_W / 8));
  localparam burst_t burst_incr = 2'b01;

  logic [cnt_w-1:0] wr_cnt;
  logic [cnt_w-1:0] rd_cnt;
  logic             aw_open;
  logic             ar_open;
  logic             aw_fire;
  logic             b_fire;
  logic             ar_fire;
  logic             r_fire;

  // Lite has no exclusive access, so an exclusive OK is just OK
  function automatic resp_t map_resp(input resp_t resp);
    return (resp == resp_exokay) ? resp_okay : resp;
  endfunction

  // Address channels only pass while there is room for another transaction.
  // The count can only reach the limit through the pending beat's own
  // handshake, so a raised valid never drops early
  assign aw_open       = wr_cnt < max_out;
  assign ar_open       = rd_cnt < max_out;
  assign axi_aw_valid  = lite_aw_valid && aw_open;
  assign lite_aw_ready = axi_aw_ready && aw_open;
  assign axi_ar_valid  = lite_ar_valid && ar_open;
  assign lite_ar_ready = axi_ar_ready && ar_open;

  // Write address completion
  assign axi_aw.id     = `AXI_BRIDGE_ID;
  assign axi_aw.addr   = lite_aw.addr;
  assign axi_aw.len    = '0;
  assign axi_aw.size   = full_size;
  assign axi_aw.burst  = burst_incr;
  assign axi_aw.lock   = 1'b0;
  assign axi_aw.cache  = '0;
  assign axi_aw.prot   = lite_aw.prot;
  assign axi_aw.qos    = '0;
  assign axi_aw.region = '0;
  assign axi_aw.user   = '0;

  // Read address completion follows the same rule
  assign axi_ar.id     = `AXI_BRIDGE_ID;
  assign axi_ar.addr   = lite_ar.addr;
  assign axi_ar.len    = '0;
  assign axi_ar.size   = full_size;
  assign axi_ar.burst  = burst_incr;
  assign axi_ar.lock   = 1'b0;
  assign axi_ar.cache  = '0;
  assign axi_ar.prot   = lite_ar.prot;
  assign axi_ar.qos    = '0;
  assign axi_ar.region = '0;
  assign axi_ar.user   = '0;

  // Write data is a single beat, so it is always the last one.
  // Each W belongs to an AW that the limit already covers
  assign axi_w.data    = lite_w.data;
  assign axi_w.strb    = lite_w.strb;
  assign axi_w.last    = 1'b1;
  assign axi_w.user    = '0;
  assign axi_w_valid   = lite_w_valid;
  assign lite_w_ready  = axi_w_ready;

  // Responses drop ID and user on the way back
  assign lite_b.resp   = map_resp(axi_b.resp);
  assign lite_b_valid  = axi_b_valid;
  assign axi_b_ready   = lite_b_ready;

  assign lite_r.data   = axi_r.data;
  assign lite_r.resp   = map_resp(axi_r.resp);
  assign lite_r_valid  = axi_r_valid;
  assign axi_r_ready   = lite_r_ready;

  assign aw_fire = axi_aw_valid && axi_aw_ready;
  assign b_fire  = lite_b_valid && lite_b_ready;
  assign ar_fire = axi_ar_valid && axi_ar_ready;
  assign r_fire  = lite_r_valid && lite_r_ready;

  // A transaction counts from its address handshake until its response
  // is handed to the lite master
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_cnt <= '0;
    end else if (aw_fire && !b_fire) begin
      wr_cnt <= wr_cnt + 1'b1;
    end else if (!aw_fire && b_fire) begin
      wr_cnt <= wr_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_cnt <= '0;
    end else if (ar_fire && !r_fire) begin
      rd_cnt <= rd_cnt + 1'b1;
    end else if (!ar_fire && r_fire) begin
      rd_cnt <= rd_cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== source/axi_chan_slice.sv ====
// Two-entry valid/ready register slice that cuts both handshake paths of one channel
`timescale 1ns/1ps
`default_nettype none

module axi_chan_slice #(
  parameter int WIDTH = 32
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic [WIDTH-1:0] in_data,
  input  wire logic             in_valid,
  output logic                  in_ready,
  output logic      [WIDTH-1:0] out_data,
  output logic                  out_valid,
  input  wire logic             out_ready
);

  // The main entry drives the output, the spill entry catches the one beat
  // that arrives in the cycle the downstream side stalls
  logic [WIDTH-1:0] main_data;
  logic             main_valid;
  logic [WIDTH-1:0] spill_data;
  logic             spill_valid;

  logic in_fire;
  logic main_free;

  // Ready comes straight from a flop, so no combinational path runs
  // from out_ready back to in_ready
  assign in_ready  = !spill_valid;
  assign in_fire   = in_valid && in_ready;

  // Main can take a new beat if it is empty or is being drained right now
  assign main_free = !main_valid || out_ready;

  assign out_data  = main_data;
  assign out_valid = main_valid;

  // Handshake state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      main_valid  <= 1'b0;
      spill_valid <= 1'b0;
    end else if (spill_valid) begin
      // No input is accepted while spill is full, so main only refills from spill
      if (out_ready) begin
        spill_valid <= 1'b0;
      end
    end else if (main_free) begin
      main_valid <= in_fire;
    end else if (in_fire) begin
      // Main is stalled and still held, park the new beat
      spill_valid <= 1'b1;
    end
  end

  // Payload registers follow the same decisions as the valid flags
  always_ff @(posedge clk) begin
    if (spill_valid) begin
      if (out_ready) begin
        main_data <= spill_data;
      end
    end else if (main_free) begin
      if (in_fire) begin
        main_data <= in_data;
      end
    end else if (in_fire) begin
      spill_data <= in_data;
    end
  end

endmodule

`default_nettype wire

// ==== source/axi_bridge_pkg.sv ====
// Bridge type package with width typedefs, response codes and the channel structs of both protocols
`default_nettype none

package axi_bridge_pkg;

  `include "axi_bridge_macros.svh"

  // Plain vectors for widths that carry a meaning
  typedef logic [`AXI_BRIDGE_ADDR_W-1:0]   addr_t;
  typedef logic [`AXI_BRIDGE_DATA_W-1:0]   data_t;
  typedef logic [`AXI_BRIDGE_DATA_W/8-1:0] strb_t;
  typedef logic [`AXI_BRIDGE_ID_W-1:0]     id_t;
  typedef logic [`AXI_BRIDGE_USER_W-1:0]   user_t;
  typedef logic [2:0]                      prot_t;

  // AXI4 burst attributes that have no AXI4-Lite counterpart
  typedef logic [7:0] len_t;
  typedef logic [2:0] size_t;
  typedef logic [1:0] burst_t;
  typedef logic [3:0] cache_t;
  typedef logic [3:0] qos_t;
  typedef logic [3:0] region_t;

  // Response codes shared by AXI4 and AXI4-Lite
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } resp_t;

  // AXI4-Lite channels carry only address, data and response
  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } lite_aw_t;

  // Read address looks exactly like write address on the lite side
  typedef lite_aw_t lite_ar_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } lite_w_t;

  typedef struct packed {
    resp_t resp;
  } lite_b_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } lite_r_t;

  // Full AXI4 address channel, same layout for AW and AR
  typedef struct packed {
    id_t     id;
    addr_t   addr;
    len_t    len;
    size_t   size;
    burst_t  burst;
    logic    lock;
    cache_t  cache;
    prot_t   prot;
    qos_t    qos;
    region_t region;
    user_t   user;
  } axi_aw_t;

  typedef axi_aw_t axi_ar_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
    user_t user;
  } axi_w_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
    user_t user;
  } axi_b_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
    user_t user;
  } axi_r_t;

endpackage

`default_nettype wire

// ==== source/axi_bridge_macros.svh ====
// AXI4-Lite to AXI4 bridge configuration, with bus widths, the fixed ID and the outstanding limit
`ifndef AXI_BRIDGE_MACROS_SVH
`define AXI_BRIDGE_MACROS_SVH

// Byte address width on both sides of the bridge
`define AXI_BRIDGE_ADDR_W 32

// Data width, which also sets the strobe width and the AXI4 beat size
`define AXI_BRIDGE_DATA_W 32

// AXI4 transaction ID width
`define AXI_BRIDGE_ID_W 8

// AXI4 user sideband width on every channel
`define AXI_BRIDGE_USER_W 8

// Every request leaves the bridge with this ID, so the slave keeps
// responses in order for us
`define AXI_BRIDGE_ID 8'h00

// Maximum number of transactions in flight per direction
`define AXI_BRIDGE_MAX_OUT 4

`endif
